//--- axil_reg_subsys.f
+incdir+src
src/axil_reg_pkg.sv
src/axil_req_arbiter.sv
src/reg_access_ctrl.sv
src/axil_resp_queue.sv
src/reg_file_bank.sv
src/axil_reg_subsys.sv
tests/axil_reg_checker.sv
tests/tb_axil_reg_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the AXI-Lite register subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_axil_reg_subsys \
  -f axil_reg_subsys.f \
  --Mdir obj_dir -o sim_axil_reg_subsys

./obj_dir/sim_axil_reg_subsys > sim.log 2>&1
cat sim.log

if grep -qx "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- src/axil_reg_cfg.svh
`ifndef AXIL_REG_CFG_SVH
`define AXIL_REG_CFG_SVH

// bus widths
`define AXIL_REG_ADDR_W 32
`define AXIL_REG_DATA_W 32

// register bank depth in 32-bit words
`define AXIL_REG_NUM_REGS 16

// entries in the response queue
`define AXIL_REG_BUF_DEPTH 2

`endif

//--- src/axil_reg_pkg.sv
`include "axil_reg_cfg.svh"

package axil_reg_pkg;

  // ##########################################################################
  // enums
  // ##########################################################################

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } acc_op_e;

  // access controller FSM
  typedef enum logic [1:0] {
    CTRL_IDLE = 2'd0,
    CTRL_WAIT = 2'd1,
    CTRL_HOLD = 2'd2
  } ctrl_state_e;

  // ##########################################################################
  // structs
  // ##########################################################################

  // arbiter output and register bus request, 69 bits
  typedef struct packed {
    acc_op_e                       op;
    logic [`AXIL_REG_ADDR_W-1:0]   addr;
    logic [`AXIL_REG_DATA_W-1:0]   wdata;
    logic [`AXIL_REG_DATA_W/8-1:0] wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [`AXIL_REG_DATA_W-1:0] rdata;
    logic                        error;
  } reg_rsp_t;

  // one completed access, as held in the response queue
  typedef struct packed {
    acc_op_e                     op;
    logic [`AXIL_REG_DATA_W-1:0] rdata;
    logic                        error;
  } axil_resp_t;

  // AXI-Lite response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- src/axil_reg_subsys.sv
`timescale 1ns/10ps
`include "axil_reg_cfg.svh"

module axil_reg_subsys (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [`AXIL_REG_ADDR_W-1:0]   awaddr_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  input  logic [`AXIL_REG_DATA_W-1:0]   wdata_i,
  input  logic [`AXIL_REG_DATA_W/8-1:0] wstrb_i,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  output logic [1:0]                    bresp_o,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  input  logic [`AXIL_REG_ADDR_W-1:0]   araddr_i,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output logic [`AXIL_REG_DATA_W-1:0]   rdata_o,
  output logic [1:0]                    rresp_o
);
  import axil_reg_pkg::*;

  // stage 1 to stage 2
  logic       acc_valid;
  logic       acc_ready;
  reg_req_t   acc_req;

  // register bus
  logic       reg_valid;
  logic       reg_ready;
  reg_req_t   reg_req;
  reg_rsp_t   reg_rsp;

  // stage 2 to stage 3
  logic       done_valid;
  logic       done_ready;
  axil_resp_t done_entry;

  axil_req_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .awaddr_i    (awaddr_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .araddr_i    (araddr_i),
    .acc_valid_o (acc_valid),
    .acc_req_o   (acc_req),
    .acc_ready_i (acc_ready)
  );

  reg_access_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .acc_valid_i  (acc_valid),
    .acc_req_i    (acc_req),
    .acc_ready_o  (acc_ready),
    .reg_valid_o  (reg_valid),
    .reg_req_o    (reg_req),
    .reg_ready_i  (reg_ready),
    .reg_rsp_i    (reg_rsp),
    .done_valid_o (done_valid),
    .done_entry_o (done_entry),
    .done_ready_i (done_ready)
  );

  axil_resp_queue u_resp_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .done_valid_i (done_valid),
    .done_entry_i (done_entry),
    .done_ready_o (done_ready),
    .bvalid_o     (bvalid_o),
    .bresp_o      (bresp_o),
    .bready_i     (bready_i),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .rready_i     (rready_i)
  );

  reg_file_bank u_bank (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_valid_i (reg_valid),
    .reg_req_i   (reg_req),
    .reg_ready_o (reg_ready),
    .reg_rsp_o   (reg_rsp)
  );

endmodule

//--- src/axil_req_arbiter.sv
`timescale 1ns/10ps
`include "axil_reg_cfg.svh"

module axil_req_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [`AXIL_REG_ADDR_W-1:0]   awaddr_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  input  logic [`AXIL_REG_DATA_W-1:0]   wdata_i,
  input  logic [`AXIL_REG_DATA_W/8-1:0] wstrb_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  input  logic [`AXIL_REG_ADDR_W-1:0]   araddr_i,
  output logic                          acc_valid_o,
  output axil_reg_pkg::reg_req_t        acc_req_o,
  input  logic                          acc_ready_i
);
  import axil_reg_pkg::*;

  // W decoupling register
  logic                          w_full_q;
  logic [`AXIL_REG_DATA_W-1:0]   w_data_q;
  logic [`AXIL_REG_DATA_W/8-1:0] w_strb_q;

  // one-entry output register
  logic     acc_valid_q;
  reg_req_t acc_req_q;

  logic prefer_rd_q;
  logic out_free;
  logic wr_pending;
  logic rd_pending;
  logic grant_wr;
  logic grant_rd;
  logic w_push;

  // output slot empty or draining this cycle
  assign out_free   = ~acc_valid_q | acc_ready_i;

  // a write is complete once AW sees a buffered W beat
  assign wr_pending = awvalid_i & w_full_q;
  assign rd_pending = arvalid_i;

  // alternate when both are pending
  assign grant_wr = out_free & wr_pending & (~rd_pending | ~prefer_rd_q);
  assign grant_rd = out_free & rd_pending & (~wr_pending | prefer_rd_q);

  assign awready_o = grant_wr;
  assign arready_o = grant_rd;
  // W beat into the buffer, never alongside an AR grant
  assign wready_o  = wvalid_i & ~w_full_q & ~grant_rd;
  assign w_push    = wvalid_i & wready_o;

  assign acc_valid_o = acc_valid_q;
  assign acc_req_o   = acc_req_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_full_q    <= 1'b0;
      acc_valid_q <= 1'b0;
      prefer_rd_q <= 1'b0;
    end else begin
      if (w_push)
        w_full_q <= 1'b1;
      else if (grant_wr)
        w_full_q <= 1'b0;

      if (grant_wr || grant_rd) begin
        acc_valid_q <= 1'b1;
        // next tie goes to the other kind
        prefer_rd_q <= grant_wr;
      end else if (acc_ready_i) begin
        acc_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_push) begin
      w_data_q <= wdata_i;
      w_strb_q <= wstrb_i;
    end

    if (grant_wr) begin
      acc_req_q.op    <= OP_WRITE;
      acc_req_q.addr  <= awaddr_i;
      acc_req_q.wdata <= w_data_q;
      acc_req_q.wstrb <= w_strb_q;
    end else if (grant_rd) begin
      acc_req_q.op    <= OP_READ;
      acc_req_q.addr  <= araddr_i;
      acc_req_q.wdata <= '0;
      acc_req_q.wstrb <= '0;
    end
  end

endmodule

//--- src/axil_resp_queue.sv
`timescale 1ns/10ps
`include "axil_reg_cfg.svh"

module axil_resp_queue (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        done_valid_i,
  input  axil_reg_pkg::axil_resp_t    done_entry_i,
  output logic                        done_ready_o,
  output logic                        bvalid_o,
  output logic [1:0]                  bresp_o,
  input  logic                        bready_i,
  output logic                        rvalid_o,
  output logic [`AXIL_REG_DATA_W-1:0] rdata_o,
  output logic [1:0]                  rresp_o,
  input  logic                        rready_i
);
  import axil_reg_pkg::*;

  localparam int DEPTH = `AXIL_REG_BUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  axil_resp_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  axil_resp_t       head;
  logic             empty;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty        = (count_q == '0);
  assign done_ready_o = (count_q != CNT_W'(DEPTH));
  assign push         = done_valid_i & done_ready_o;

  // ##########################################################################
  // head entry steered to B or R, strict FIFO order
  // ##########################################################################

  assign head     = mem_q[rd_ptr_q];
  assign bvalid_o = ~empty & (head.op == OP_WRITE);
  assign rvalid_o = ~empty & (head.op == OP_READ);
  assign pop      = (bvalid_o & bready_i) | (rvalid_o & rready_i);

  assign bresp_o  = head.error ? RESP_SLVERR : RESP_OKAY;
  assign rresp_o  = head.error ? RESP_SLVERR : RESP_OKAY;
  assign rdata_o  = head.error ? '0 : head.rdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      mem_q[wr_ptr_q] <= done_entry_i;
  end

endmodule

//--- src/reg_access_ctrl.sv
`timescale 1ns/10ps

module reg_access_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     acc_valid_i,
  input  axil_reg_pkg::reg_req_t   acc_req_i,
  output logic                     acc_ready_o,
  output logic                     reg_valid_o,
  output axil_reg_pkg::reg_req_t   reg_req_o,
  input  logic                     reg_ready_i,
  input  axil_reg_pkg::reg_rsp_t   reg_rsp_i,
  output logic                     done_valid_o,
  output axil_reg_pkg::axil_resp_t done_entry_o,
  input  logic                     done_ready_i
);
  import axil_reg_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  reg_req_t    req_q;
  axil_resp_t  entry_q;
  logic        acc_fire;
  logic        reg_fire;

  assign acc_ready_o  = (state_q == CTRL_IDLE);
  assign acc_fire     = acc_valid_i & acc_ready_o;

  // register bus side, request held stable while waiting
  assign reg_valid_o  = (state_q == CTRL_WAIT);
  assign reg_req_o    = req_q;
  assign reg_fire     = reg_valid_o & reg_ready_i;

  assign done_valid_o = (state_q == CTRL_HOLD);
  assign done_entry_o = entry_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: if (acc_fire) state_d = CTRL_WAIT;
      CTRL_WAIT: if (reg_fire) state_d = CTRL_HOLD;
      // stays here while the queue is full
      CTRL_HOLD: if (done_ready_i) state_d = CTRL_IDLE;
      default:   state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_fire)
      req_q <= acc_req_i;
    if (reg_fire) begin
      entry_q.op    <= req_q.op;
      entry_q.rdata <= reg_rsp_i.rdata;
      entry_q.error <= reg_rsp_i.error;
    end
  end

endmodule

//--- src/reg_file_bank.sv
`timescale 1ns/10ps
`include "axil_reg_cfg.svh"

module reg_file_bank (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   reg_valid_i,
  input  axil_reg_pkg::reg_req_t reg_req_i,
  output logic                   reg_ready_o,
  output axil_reg_pkg::reg_rsp_t reg_rsp_o
);
  import axil_reg_pkg::*;

  localparam int NUM_REGS = `AXIL_REG_NUM_REGS;
  localparam int IDX_W    = $clog2(NUM_REGS);
  localparam int NUM_B    = `AXIL_REG_DATA_W / 8;

  logic [`AXIL_REG_DATA_W-1:0] regs_q [NUM_REGS];
  logic                        ready_q;
  reg_rsp_t                    rsp_q;
  logic                        access;
  logic                        hit;
  logic [IDX_W-1:0]            idx;

  // one response per request, ready pulses the cycle after valid
  assign access = reg_valid_i & ~ready_q;
  assign idx    = reg_req_i.addr[IDX_W+1:2];
  // inside the bank and word aligned
  assign hit    = (reg_req_i.addr < `AXIL_REG_ADDR_W'(NUM_REGS * 4)) &&
                  (reg_req_i.addr[1:0] == 2'b00);

  assign reg_ready_o = ready_q;
  assign reg_rsp_o   = rsp_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      regs_q  <= '{default: '0};
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
      if (access && hit && reg_req_i.op == OP_WRITE) begin
        // byte merge under wstrb
        for (int b = 0; b < NUM_B; b++) begin
          if (reg_req_i.wstrb[b])
            regs_q[idx][8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rsp_q.error <= ~hit;
      rsp_q.rdata <= (hit && reg_req_i.op == OP_READ) ? regs_q[idx] : '0;
    end
  end

endmodule

//--- tests/axil_reg_checker.sv
`timescale 1ns/10ps
`include "axil_reg_cfg.svh"

module axil_reg_checker (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          awvalid_i,
  input  logic                          awready_o,
  input  logic [`AXIL_REG_ADDR_W-1:0]   awaddr_i,
  input  logic                          wvalid_i,
  input  logic                          wready_o,
  input  logic [`AXIL_REG_DATA_W-1:0]   wdata_i,
  input  logic [`AXIL_REG_DATA_W/8-1:0] wstrb_i,
  input  logic                          bvalid_o,
  input  logic                          bready_i,
  input  logic [1:0]                    bresp_o,
  input  logic                          arvalid_i,
  input  logic                          arready_o,
  input  logic [`AXIL_REG_ADDR_W-1:0]   araddr_i,
  input  logic                          rvalid_o,
  input  logic                          rready_i,
  input  logic [`AXIL_REG_DATA_W-1:0]   rdata_o,
  input  logic [1:0]                    rresp_o,
  output int                            errors_o,
  output int                            pending_o
);
  import axil_reg_pkg::*;

  localparam int NUM_REGS = `AXIL_REG_NUM_REGS;
  localparam int IDX_W    = $clog2(NUM_REGS);
  // quarter period after the falling edge, all ports settled
  localparam int SETTLE   = 25;

  logic [`AXIL_REG_DATA_W-1:0]   model_q [NUM_REGS] = '{default: '0};
  logic [`AXIL_REG_ADDR_W-1:0]   aw_addr_q [$];
  logic [`AXIL_REG_DATA_W-1:0]   w_data_q [$];
  logic [`AXIL_REG_DATA_W/8-1:0] w_strb_q [$];
  logic [1:0]                    exp_bresp [$];
  logic [1:0]                    exp_rresp [$];
  logic [`AXIL_REG_DATA_W-1:0]   exp_rdata [$];
  int                            errors = 0;
  int                            pending = 0;

  assign errors_o  = errors;
  assign pending_o = pending;

  // ##########################################################################
  // reference model of the 16-word bank
  // ##########################################################################

  function automatic void ref_access(input logic is_wr,
                                     input logic [`AXIL_REG_ADDR_W-1:0] addr,
                                     input logic [`AXIL_REG_DATA_W-1:0] wdata,
                                     input logic [`AXIL_REG_DATA_W/8-1:0] wstrb,
                                     output logic [1:0] resp,
                                     output logic [`AXIL_REG_DATA_W-1:0] rdata);
    logic             hit;
    logic [IDX_W-1:0] idx;
    hit   = (addr < NUM_REGS * 4) && (addr[1:0] == 2'b00);
    idx   = addr[IDX_W+1:2];
    resp  = hit ? RESP_OKAY : RESP_SLVERR;
    rdata = '0;
    if (hit && is_wr) begin
      for (int b = 0; b < `AXIL_REG_DATA_W / 8; b++) begin
        if (wstrb[b])
          model_q[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end else if (hit) begin
      rdata = model_q[idx];
    end
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic sample_ports();
    logic [1:0]                  resp;
    logic [`AXIL_REG_DATA_W-1:0] rdata;
    // responses first, they belong to older accesses
    if (bvalid_o && bready_i) begin
      if (exp_bresp.size() == 0) begin
        $display("%0t ns: write response seen with no write outstanding", $time);
        errors++;
      end else begin
        compare_value("bresp_o", 32'(bresp_o), 32'(exp_bresp.pop_front()));
      end
    end
    if (rvalid_o && rready_i) begin
      if (exp_rresp.size() == 0) begin
        $display("%0t ns: read response seen with no read outstanding", $time);
        errors++;
      end else begin
        compare_value("rresp_o", 32'(rresp_o), 32'(exp_rresp.pop_front()));
        compare_value("rdata_o", rdata_o, exp_rdata.pop_front());
      end
    end
    if (arready_o && (awready_o || wready_o)) begin
      $display("%0t ns: read and write channels were ready in the same cycle", $time);
      errors++;
    end
    // requests in acceptance order
    if (wvalid_i && wready_o) begin
      w_data_q.push_back(wdata_i);
      w_strb_q.push_back(wstrb_i);
    end
    if (awvalid_i && awready_o)
      aw_addr_q.push_back(awaddr_i);
    if (arvalid_i && arready_o) begin
      ref_access(1'b0, araddr_i, '0, '0, resp, rdata);
      exp_rresp.push_back(resp);
      exp_rdata.push_back(rdata);
    end
    while (aw_addr_q.size() != 0 && w_data_q.size() != 0) begin
      ref_access(1'b1, aw_addr_q.pop_front(), w_data_q.pop_front(), w_strb_q.pop_front(),
                 resp, rdata);
      exp_bresp.push_back(resp);
    end
    pending = exp_bresp.size() + exp_rresp.size() + aw_addr_q.size() + w_data_q.size();
  endtask

  always begin
    @(negedge clk_i);
    #(SETTLE);
    if (rst_n_i)
      sample_ports();
  end

endmodule

//--- tests/tb_axil_reg_subsys.sv
`timescale 1ns/10ps
`include "axil_reg_cfg.svh"

module tb_axil_reg_subsys;

  localparam int PERIOD  = 100;
  localparam int SETTLE  = PERIOD / 4;
  localparam int TIMEOUT = 100;

  logic                          clk_i;
  logic                          rst_n_i;
  logic                          awvalid_i;
  logic                          awready_o;
  logic [`AXIL_REG_ADDR_W-1:0]   awaddr_i;
  logic                          wvalid_i;
  logic                          wready_o;
  logic [`AXIL_REG_DATA_W-1:0]   wdata_i;
  logic [`AXIL_REG_DATA_W/8-1:0] wstrb_i;
  logic                          bvalid_o;
  logic                          bready_i;
  logic [1:0]                    bresp_o;
  logic                          arvalid_i;
  logic                          arready_o;
  logic [`AXIL_REG_ADDR_W-1:0]   araddr_i;
  logic                          rvalid_o;
  logic                          rready_i;
  logic [`AXIL_REG_DATA_W-1:0]   rdata_o;
  logic [1:0]                    rresp_o;
  int                            chk_errors;
  int                            chk_pending;
  int                            timeouts;
  int                            lost;
  bit                            stall_en;

  axil_reg_subsys dut (.*);

  axil_reg_checker chk (.*, .errors_o(chk_errors), .pending_o(chk_pending));

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  // B and R ready with random stalls when enabled
  initial begin
    bready_i = 1'b0;
    rready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      bready_i = stall_en ? ($urandom_range(0, 3) != 0) : 1'b1;
      rready_i = stall_en ? ($urandom_range(0, 3) != 0) : 1'b1;
    end
  end

  // order selects AW and W together (0), AW first (1) or W first (2)
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int order);
    int cycles;
    bit aw_done;
    bit w_done;
    @(negedge clk_i);
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = (order != 2);
    wvalid_i  = (order != 1);
    aw_done   = 1'b0;
    w_done    = 1'b0;
    cycles    = 0;
    while (!(aw_done && w_done) && cycles < TIMEOUT) begin
      #(SETTLE);
      if (awvalid_i && awready_o)
        aw_done = 1'b1;
      if (wvalid_i && wready_o)
        w_done = 1'b1;
      @(negedge clk_i);
      cycles++;
      if (aw_done)
        awvalid_i = 1'b0;
      if (w_done)
        wvalid_i = 1'b0;
      // the late channel joins after two cycles
      if (cycles == 2 && order == 1)
        wvalid_i = 1'b1;
      if (cycles == 2 && order == 2)
        awvalid_i = 1'b1;
    end
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    if (!(aw_done && w_done)) begin
      $display("timeout: write to address 0x%08h was never accepted", addr);
      timeouts++;
    end
  endtask

  task automatic axil_read(input logic [31:0] addr);
    int cycles;
    bit done;
    @(negedge clk_i);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    done      = 1'b0;
    cycles    = 0;
    while (!done && cycles < TIMEOUT) begin
      #(SETTLE);
      done = arready_o;
      @(negedge clk_i);
      cycles++;
    end
    arvalid_i = 1'b0;
    if (!done) begin
      $display("timeout: read of address 0x%08h was never accepted", addr);
      timeouts++;
    end
  endtask

  task automatic drain_responses();
    int cycles;
    stall_en = 1'b0;
    cycles   = 0;
    while (chk_pending != 0 && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (chk_pending != 0) begin
      $display("timeout: %0d accesses still wait for a response", chk_pending);
      timeouts++;
    end
  endtask

  initial begin
    logic [31:0] addr;
    void'($urandom(94));
    rst_n_i   = 1'b0;
    awvalid_i = 1'b0;
    awaddr_i  = '0;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    arvalid_i = 1'b0;
    araddr_i  = '0;
    stall_en  = 1'b0;
    timeouts  = 0;
    lost      = 0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;

    // ##########################################################################
    // directed sequences
    // ##########################################################################

    axil_write(32'h0, 32'hA5A5_1234, 4'hF, 0);
    axil_read(32'h0);
    // partial strobe merge
    axil_write(32'h4, 32'h1122_3344, 4'hF, 0);
    axil_write(32'h4, 32'hAABB_CCDD, 4'b0101, 0);
    axil_read(32'h4);
    // out of range and misaligned
    axil_write(32'h40, 32'hDEAD_BEEF, 4'hF, 0);
    axil_read(32'h40);
    axil_write(32'h6, 32'hFFFF_FFFF, 4'hF, 0);
    axil_read(32'h6);
    axil_read(32'h4);
    axil_read(32'h0);
    // channel orderings
    axil_write(32'h8, 32'h0808_0808, 4'hF, 1);
    axil_write(32'hC, 32'h0C0C_0C0C, 4'hF, 2);
    axil_write(32'h10, 32'h1010_1010, 4'hF, 0);
    axil_read(32'h8);
    axil_read(32'hC);
    axil_read(32'h10);
    drain_responses();

    // ##########################################################################
    // random mixed stream with response stalls
    // ##########################################################################

    stall_en = 1'b1;
    for (int i = 0; i < 200; i++) begin
      if ($urandom_range(0, 7) == 0)
        addr = 32'($urandom_range(0, 'h4C));
      else
        addr = 32'($urandom_range(0, 19) * 4);
      case ($urandom_range(0, 2))
        0: axil_read(addr);
        1: axil_write(addr, $urandom, 4'($urandom_range(0, 15)), $urandom_range(0, 2));
        default: begin
          // read and write pending together exercise the alternation
          fork
            axil_write(addr, $urandom, 4'hF, 0);
            axil_read(32'($urandom_range(0, 19) * 4));
          join
        end
      endcase
    end
    drain_responses();

    if (chk_pending != 0) begin
      $display("%0d accesses still have no response at the end of the run", chk_pending);
      lost = chk_pending;
    end
    $display("closing report: checker errors %0d, timeouts %0d, missing responses %0d",
             chk_errors, timeouts, lost);
    if (chk_errors == 0 && timeouts == 0 && lost == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
